/* stack_cpu_pkg.sv */
`default_nettype none

package stack_cpu_pkg;

  // basic widths
  typedef logic [15:0] word_t;    // data word, stack entries, pointer registers
  typedef logic [17:0] insn_t;    // one program memory word
  typedef logic [5:0]  alu_op_t;  // same layout as the ALU field of binop and stack ops

  // alu function codes
  // binary ops take the second operand as b and the top as a, so SUB is b - a
  localparam alu_op_t ALU_PASS_A = 6'h00;  // also NOP and DUP
  localparam alu_op_t ALU_INC    = 6'h01;  // a + 1
  localparam alu_op_t ALU_NOT    = 6'h04;
  localparam alu_op_t ALU_PASS_B = 6'h0f;  // POP keeps the second entry
  localparam alu_op_t ALU_AND    = 6'h10;
  localparam alu_op_t ALU_OR     = 6'h11;
  localparam alu_op_t ALU_XOR    = 6'h12;
  localparam alu_op_t ALU_SHR    = 6'h14;  // b >> a, zero fill
  localparam alu_op_t ALU_SHL    = 6'h16;  // b << a
  localparam alu_op_t ALU_ADD    = 6'h20;  // b added to a, also for addresses and jumps
  localparam alu_op_t ALU_SUB    = 6'h21;  // b - a
  localparam alu_op_t ALU_EQ     = 6'h28;  // 1 when equal
  localparam alu_op_t ALU_LT     = 6'h2a;  // signed b < a
  localparam alu_op_t ALU_BZ     = 6'h30;  // a + b when test word is zero, else a

  // frame pointer after reset, frames grow toward 0
  localparam word_t FP_RESET = 16'h4000;

  // alu input A select
  typedef enum logic [2:0] {
    SRCA_STK,   // operand stack top
    SRCA_FP,
    SRCA_DP,
    SRCA_IP,
    SRCA_CSTK,  // call stack top
    SRCA_ZERO   // X = 0 in X-relative forms
  } src_a_t;

  // alu input B select
  typedef enum logic {
    SRCB_STK1,  // second stack entry
    SRCB_IMM    // decoded immediate
  } src_b_t;

  // decoder phases
  typedef enum logic [1:0] {
    FETCH,    // pmem_addr = ip, ip advances
    LATCH,    // insn takes pmem_rdata
    EXEC,     // operation and memory strobes
    LOAD_WB   // load data onto the stack
  } phase_t;

  // decoder to core, one set per cycle
  typedef struct packed {
    alu_op_t alu_op;
    src_a_t  src_a;
    src_b_t  src_b;
    logic    pop;        // operand stack pop
    logic    push;       // operand stack push
    logic    load_stk;   // top takes stack_in
    logic    load_fp;    // fp takes alu out
    logic    load_dp;
    logic    load_ip;
    logic    load_insn;  // insn takes pmem_rdata
    logic    cpop;       // call stack pop
    logic    cpush;      // call stack push of alu input A
    logic    wr_stk1;    // write data from second entry instead of top
    logic    rd_mem;
    logic    wr_mem;
  } ctrl_t;

endpackage

`default_nettype wire

/* stack.sv */
`timescale 1ns/1ns
`default_nettype none

module stack #(
  parameter int DEPTH = 16  // entries held below the top two
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        pop,
  input  wire                        push,
  input  wire                        load,
  input  wire stack_cpu_pkg::word_t  data_in,
  output stack_cpu_pkg::word_t       top,
  output stack_cpu_pkg::word_t       next
);

  localparam int PW = $clog2(DEPTH);

  stack_cpu_pkg::word_t mem [DEPTH];  // third entry and deeper
  logic [PW-1:0] ptr;                  // first free slot in mem

  // spill the second entry on push
  always_ff @(posedge clk) begin
    if (push)
      mem[ptr] <= next;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ptr  <= '0;
      top  <= '0;
      next <= '0;
    end else if (push) begin
      ptr  <= ptr + PW'(1);
      next <= top;  // old top moves down
      if (load)
        top <= data_in;  // push with load puts data_in on top
    end else if (pop) begin
      ptr  <= ptr - PW'(1);
      next <= mem[ptr - PW'(1)];    // refill from the array
      top  <= load ? data_in : next;  // binary ops replace the new top
    end else if (load) begin
      top <= data_in;  // in-place update
    end
  end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  wire stack_cpu_pkg::word_t    a,
  input  wire stack_cpu_pkg::word_t    b,
  input  wire stack_cpu_pkg::word_t    test,  // operand stack top, for JZ
  input  wire stack_cpu_pkg::alu_op_t  op,
  output stack_cpu_pkg::word_t         out
);

  stack_cpu_pkg::word_t addend;  // b, or 1 for INC
  stack_cpu_pkg::word_t sum;     // shared by ADD, INC and BZ
  stack_cpu_pkg::word_t diff;
  logic                 eq;
  logic                 lt;
  logic                 test_zero;

  // one adder for all add-type ops
  assign addend = (op == stack_cpu_pkg::ALU_INC) ? stack_cpu_pkg::word_t'(1) : b;
  assign sum    = a + addend;
  assign diff   = b - a;  // second entry minus top

  // compares return 0 or 1
  assign eq = (a == b);
  assign lt = ($signed(b) < $signed(a));

  assign test_zero = (test == '0);

  always_comb begin
    case (op)
      stack_cpu_pkg::ALU_PASS_A: out = a;
      stack_cpu_pkg::ALU_INC:    out = sum;
      stack_cpu_pkg::ALU_NOT:    out = ~a;
      stack_cpu_pkg::ALU_PASS_B: out = b;
      stack_cpu_pkg::ALU_AND:    out = a & b;
      stack_cpu_pkg::ALU_OR:     out = a | b;
      stack_cpu_pkg::ALU_XOR:    out = a ^ b;
      stack_cpu_pkg::ALU_SHR:    out = b >> a;  // logical, large counts give 0
      stack_cpu_pkg::ALU_SHL:    out = b << a;
      stack_cpu_pkg::ALU_ADD:    out = sum;
      stack_cpu_pkg::ALU_SUB:    out = diff;
      stack_cpu_pkg::ALU_EQ:     out = stack_cpu_pkg::word_t'(eq);
      stack_cpu_pkg::ALU_LT:     out = stack_cpu_pkg::word_t'(lt);
      stack_cpu_pkg::ALU_BZ:     out = test_zero ? sum : a;  // branch target or fall through
      default:                   out = a;  // unused codes act as pass A
    endcase
  end

endmodule

`default_nettype wire

/* insn_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module insn_decoder (
  input  wire                        clk,
  input  wire                        rst,
  input  wire stack_cpu_pkg::insn_t  insn,
  output stack_cpu_pkg::ctrl_t       ctrl,
  output stack_cpu_pkg::word_t       imm
);

  stack_cpu_pkg::phase_t phase;
  stack_cpu_pkg::phase_t phase_next;
  stack_cpu_pkg::src_a_t x_src;  // base of the X-relative forms

  // instruction classes
  logic is_push16;
  logic is_binop;
  logic is_call;
  logic is_jmp;
  logic is_addfp;
  logic is_jz;
  logic is_ldst;   // insn[0] set for ST
  logic is_pushx;
  logic is_stk;    // stack-only ops
  logic is_misc;   // RET, CPOP, CPUSH, POP X

  assign is_push16 = (insn[17:16] == 2'b11);
  assign is_binop  = (insn[17:16] == 2'b10);
  assign is_call   = (insn[17:14] == 4'b0000);
  assign is_jmp    = (insn[17:12] == 6'b000100);
  assign is_addfp  = (insn[17:12] == 6'b000101);
  assign is_jz     = (insn[17:12] == 6'b000110);
  assign is_ldst   = (insn[17:14] == 4'b0100);
  assign is_pushx  = (insn[17:14] == 4'b0101);
  assign is_stk    = (insn[17:11] == 7'b0111000);
  assign is_misc   = (insn[17:11] == 7'b0111001);

  // X field
  always_comb begin
    case (insn[13:12])
      2'd1:    x_src = stack_cpu_pkg::SRCA_FP;
      2'd2:    x_src = stack_cpu_pkg::SRCA_DP;
      default: x_src = stack_cpu_pkg::SRCA_ZERO;  // 0 and the reserved code
    endcase
  end

  // immediate extraction per format
  always_comb begin
    if (is_push16)
      imm = insn[15:0];
    else if (is_call)
      imm = {{2{insn[13]}}, insn[13:0]};  // simm14
    else if (is_jmp || is_addfp || is_jz)
      imm = {{4{insn[11]}}, insn[11:0]};  // simm12
    else if (is_ldst)
      imm = {4'b0, insn[11:1], 1'b0};     // low bit is the ST flag, word aligned
    else if (is_pushx)
      imm = {4'b0, insn[11:0]};
    else if (is_binop)
      imm = {6'b0, insn[9:0]};
    else
      imm = '0;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst)
      phase <= stack_cpu_pkg::FETCH;
    else
      phase <= phase_next;
  end

  always_comb begin
    case (phase)
      stack_cpu_pkg::FETCH: phase_next = stack_cpu_pkg::LATCH;
      stack_cpu_pkg::LATCH: phase_next = stack_cpu_pkg::EXEC;
      stack_cpu_pkg::EXEC:
        phase_next = ctrl.rd_mem ? stack_cpu_pkg::LOAD_WB : stack_cpu_pkg::FETCH;
      default:              phase_next = stack_cpu_pkg::FETCH;
    endcase
  end

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = stack_cpu_pkg::ALU_PASS_A;
    case (phase)
      stack_cpu_pkg::FETCH: begin
        ctrl.src_a   = stack_cpu_pkg::SRCA_IP;
        ctrl.alu_op  = stack_cpu_pkg::ALU_INC;
        ctrl.load_ip = 1'b1;  // ip moves past the word being fetched
      end
      stack_cpu_pkg::LATCH: ctrl.load_insn = 1'b1;
      stack_cpu_pkg::LOAD_WB: begin
        ctrl.push     = 1'b1;  // stack_in carries dmem_rdata here
        ctrl.load_stk = 1'b1;
      end
      default: begin
        ctrl.src_b = stack_cpu_pkg::SRCB_IMM;
        if (is_push16) begin
          ctrl.alu_op   = stack_cpu_pkg::ALU_PASS_B;
          ctrl.push     = 1'b1;
          ctrl.load_stk = 1'b1;
        end else if (is_binop) begin
          ctrl.alu_op   = insn[15:10];  // imm op top
          ctrl.load_stk = 1'b1;
        end else if (is_call || is_jmp) begin
          ctrl.src_a   = stack_cpu_pkg::SRCA_IP;  // ip already points past this insn
          ctrl.alu_op  = stack_cpu_pkg::ALU_ADD;
          ctrl.load_ip = 1'b1;
          ctrl.cpush   = is_call;  // return address is alu input A
        end else if (is_jz) begin
          ctrl.src_a   = stack_cpu_pkg::SRCA_IP;
          ctrl.alu_op  = stack_cpu_pkg::ALU_BZ;
          ctrl.load_ip = 1'b1;
          ctrl.pop     = 1'b1;  // condition is consumed
        end else if (is_addfp) begin
          ctrl.src_a   = stack_cpu_pkg::SRCA_FP;
          ctrl.alu_op  = stack_cpu_pkg::ALU_ADD;
          ctrl.load_fp = 1'b1;
        end else if (is_ldst) begin
          ctrl.src_a  = x_src;
          ctrl.alu_op = stack_cpu_pkg::ALU_ADD;  // address on alu out
          ctrl.wr_mem = insn[0];
          ctrl.pop    = insn[0];   // ST drops the stored value
          ctrl.rd_mem = ~insn[0];  // LD pushes in LOAD_WB
        end else if (is_pushx) begin
          ctrl.src_a    = x_src;
          ctrl.alu_op   = stack_cpu_pkg::ALU_ADD;
          ctrl.push     = 1'b1;
          ctrl.load_stk = 1'b1;
        end else if (is_stk) begin
          ctrl.src_b    = stack_cpu_pkg::SRCB_STK1;
          ctrl.alu_op   = insn[5:0];
          ctrl.push     = insn[7];
          ctrl.pop      = insn[6];
          ctrl.load_stk = 1'b1;  // NOP rewrites the top with itself
        end else if (is_misc) begin
          case (insn[5:0])
            6'b000000: begin  // RET
              ctrl.src_a   = stack_cpu_pkg::SRCA_CSTK;
              ctrl.load_ip = 1'b1;
              ctrl.cpop    = 1'b1;
            end
            6'b000010: begin  // CPOP FP
              ctrl.src_a   = stack_cpu_pkg::SRCA_CSTK;
              ctrl.load_fp = 1'b1;
              ctrl.cpop    = 1'b1;
            end
            6'b000011: begin  // CPUSH FP
              ctrl.src_a = stack_cpu_pkg::SRCA_FP;
              ctrl.cpush = 1'b1;
            end
            6'b100000, 6'b100001: begin  // POP fp or dp
              ctrl.load_fp = ~insn[0];
              ctrl.load_dp = insn[0];
              ctrl.pop     = 1'b1;
            end
            default: ;  // unsupported acts as NOP
          endcase
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu #(
  parameter int ADDR_WIDTH   = 16,  // memory address bits, at most 16
  parameter int DSTACK_DEPTH = 16,
  parameter int CSTACK_DEPTH = 16
) (
  input  wire                        clk,
  input  wire                        rst,
  output logic [ADDR_WIDTH-1:0]      pmem_addr,
  input  wire stack_cpu_pkg::insn_t  pmem_rdata,
  output logic                       dmem_ren,
  output logic                       dmem_wen,
  output logic [ADDR_WIDTH-1:0]      dmem_addr,
  input  wire stack_cpu_pkg::word_t  dmem_rdata,
  output stack_cpu_pkg::word_t       dmem_wdata
);

  stack_cpu_pkg::ctrl_t ctrl;
  stack_cpu_pkg::word_t imm;

  // architectural registers
  stack_cpu_pkg::word_t ip;
  stack_cpu_pkg::word_t fp;
  stack_cpu_pkg::word_t dp;
  stack_cpu_pkg::insn_t insn;
  logic                 ren_d;  // load data arrives this cycle

  // datapath
  stack_cpu_pkg::word_t stack0;   // operand stack top
  stack_cpu_pkg::word_t stack1;
  stack_cpu_pkg::word_t cstack0;  // call stack top
  stack_cpu_pkg::word_t src_a;
  stack_cpu_pkg::word_t src_b;
  stack_cpu_pkg::word_t alu_out;
  stack_cpu_pkg::word_t stack_in;

  insn_decoder decoder (
    .clk  (clk),
    .rst  (rst),
    .insn (insn),
    .ctrl (ctrl),
    .imm  (imm)
  );

  // operand A mux
  always_comb begin
    case (ctrl.src_a)
      stack_cpu_pkg::SRCA_FP:   src_a = fp;
      stack_cpu_pkg::SRCA_DP:   src_a = dp;
      stack_cpu_pkg::SRCA_IP:   src_a = ip;
      stack_cpu_pkg::SRCA_CSTK: src_a = cstack0;
      stack_cpu_pkg::SRCA_ZERO: src_a = '0;
      default:                  src_a = stack0;
    endcase
  end

  assign src_b = (ctrl.src_b == stack_cpu_pkg::SRCB_IMM) ? imm : stack1;

  alu alu_unit (
    .a    (src_a),
    .b    (src_b),
    .test (stack0),  // JZ condition
    .op   (ctrl.alu_op),
    .out  (alu_out)
  );

  assign stack_in = ren_d ? dmem_rdata : alu_out;  // LD writeback or alu result

  stack #(.DEPTH(DSTACK_DEPTH)) dstack (
    .clk     (clk),
    .rst     (rst),
    .pop     (ctrl.pop),
    .push    (ctrl.push),
    .load    (ctrl.load_stk),
    .data_in (stack_in),
    .top     (stack0),
    .next    (stack1)
  );

  // holds return addresses and saved fp, pushes whatever drives alu input A
  stack #(.DEPTH(CSTACK_DEPTH)) cstack (
    .clk     (clk),
    .rst     (rst),
    .pop     (ctrl.cpop),
    .push    (ctrl.cpush),
    .load    (ctrl.cpush),
    .data_in (src_a),
    .top     (cstack0),
    .next    ()
  );

  // memory ports
  assign pmem_addr  = ip[ADDR_WIDTH-1:0];
  assign dmem_addr  = alu_out[ADDR_WIDTH-1:0];  // X + offset
  assign dmem_wdata = ctrl.wr_stk1 ? stack1 : stack0;
  assign dmem_ren   = ctrl.rd_mem;
  assign dmem_wen   = ctrl.wr_mem;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ip    <= '0;
      fp    <= stack_cpu_pkg::FP_RESET;
      dp    <= '0;
      insn  <= '0;
      ren_d <= 1'b0;
    end else begin
      if (ctrl.load_ip)
        ip <= alu_out;  // +1 in FETCH, target in EXEC
      if (ctrl.load_fp)
        fp <= alu_out;
      if (ctrl.load_dp)
        dp <= alu_out;
      if (ctrl.load_insn)
        insn <= pmem_rdata;
      ren_d <= ctrl.rd_mem;  // one cycle read latency
    end
  end

endmodule

`default_nettype wire

/* cpu_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_properties (
  input wire                          clk,
  input wire                          rst,
  input wire stack_cpu_pkg::ctrl_t    ctrl,
  input wire stack_cpu_pkg::phase_t   phase
);

  // never read and write in one cycle
  no_rd_and_wr: assert property (@(posedge clk) disable iff (rst)
    !(ctrl.rd_mem && ctrl.wr_mem))
    else $error("rd_mem and wr_mem high together");

  // strobes belong to EXEC only
  strobe_in_exec: assert property (@(posedge clk) disable iff (rst)
    (ctrl.rd_mem || ctrl.wr_mem) |-> phase == stack_cpu_pkg::EXEC)
    else $error("memory strobe outside EXEC");

  load_wb_after_read: assert property (@(posedge clk) disable iff (rst)
    phase == stack_cpu_pkg::LOAD_WB |->
      ($past(phase) == stack_cpu_pkg::EXEC && $past(ctrl.rd_mem)))
    else $error("LOAD_WB without a preceding read in EXEC");

endmodule

bind insn_decoder cpu_properties props (
  .clk   (clk),
  .rst   (rst),
  .ctrl  (ctrl),
  .phase (phase)
);

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

  // one expected data write
  typedef struct packed {
    stack_cpu_pkg::word_t addr;
    stack_cpu_pkg::word_t data;
  } wr_t;

  logic                 clk = 1'b0;
  logic                 rst;
  logic [15:0]          pmem_addr;
  stack_cpu_pkg::insn_t pmem_rdata;
  logic                 dmem_ren;
  logic                 dmem_wen;
  logic [15:0]          dmem_addr;
  stack_cpu_pkg::word_t dmem_rdata;
  stack_cpu_pkg::word_t dmem_wdata;

  stack_cpu_pkg::insn_t pmem [1024];
  stack_cpu_pkg::word_t dmem [65536];
  stack_cpu_pkg::word_t mmem [stack_cpu_pkg::word_t];  // model memory, only written words
  logic [9:0]           paddr_q = '0;
  logic [15:0]          raddr_q = '0;
  wr_t                  exp_q [$];  // model writes in order
  stack_cpu_pkg::word_t rd_q [$];   // model read addresses in order
  int                   n_writes;
  int                   n_expected;
  int                   pc;
  int                   cyc = 0;
  int                   start_cyc = 0;
  int                   limit = 1000;

  cpu #(.ADDR_WIDTH(16), .DSTACK_DEPTH(16), .CSTACK_DEPTH(8)) uut (
    .clk        (clk),
    .rst        (rst),
    .pmem_addr  (pmem_addr),
    .pmem_rdata (pmem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata)
  );

  always #5 clk = ~clk;

  task automatic abort(input string msg);
    $display("%0t ns: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input stack_cpu_pkg::word_t got,
                       input stack_cpu_pkg::word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // cycle budget per program, set by the model
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc - start_cyc > limit)
      abort("watchdog expired before the program reached its halt loop");
  end

  // both memories answer one cycle after the address
  always @(negedge clk) begin
    pmem_rdata <= pmem[paddr_q];
    paddr_q    <= pmem_addr[9:0];
    dmem_rdata <= dmem[raddr_q];
    if (!rst && dmem_ren) begin
      if (rd_q.size() == 0) begin
        abort("data read seen that the model did not expect");
      end else begin
        check("dmem_addr on read", dmem_addr, rd_q[0]);
        rd_q.delete(0);
        raddr_q <= dmem_addr;
      end
    end
    if (!rst && dmem_wen) begin
      if (exp_q.size() == 0) begin
        abort("data write seen after the model ran out of writes");
      end else begin
        check("dmem_addr", dmem_addr, exp_q[0].addr);
        check("dmem_wdata", dmem_wdata, exp_q[0].data);
        exp_q.delete(0);
        dmem[dmem_addr] <= dmem_wdata;
        n_writes++;
      end
    end
  end

  function automatic stack_cpu_pkg::word_t fill(input int a);
    return stack_cpu_pkg::word_t'((a * 40503) ^ 23235);  // every address bit matters
  endfunction

  // instruction encodings
  function automatic stack_cpu_pkg::insn_t push16(input stack_cpu_pkg::word_t v);
    return {2'b11, v};
  endfunction

  function automatic stack_cpu_pkg::insn_t binop_imm(input stack_cpu_pkg::alu_op_t op,
                                                     input logic [9:0] v);
    return {2'b10, op, v};
  endfunction

  function automatic stack_cpu_pkg::insn_t stack_op(input logic psh, input logic pp,
                                                    input stack_cpu_pkg::alu_op_t op);
    return {7'b0111000, 3'b000, psh, pp, op};
  endfunction

  function automatic stack_cpu_pkg::insn_t misc_op(input logic [5:0] code);
    return {7'b0111001, 5'b00000, code};  // 0 RET, 2 CPOP, 3 CPUSH, 20/21 POP fp/dp
  endfunction

  function automatic stack_cpu_pkg::insn_t mem_access(input logic [1:0] x, input int off,
                                                      input logic st);
    return {4'b0100, x, off[11:1], st};
  endfunction

  function automatic stack_cpu_pkg::insn_t push_x(input logic [1:0] x, input int off);
    return {4'b0101, x, off[11:0]};
  endfunction

  function automatic stack_cpu_pkg::insn_t call_to(input int off);
    return {4'b0000, off[13:0]};
  endfunction

  function automatic stack_cpu_pkg::insn_t jump(input int off);
    return {6'b000100, off[11:0]};
  endfunction

  function automatic stack_cpu_pkg::insn_t add_fp(input int off);
    return {6'b000101, off[11:0]};
  endfunction

  function automatic stack_cpu_pkg::insn_t jump_zero(input int off);
    return {6'b000110, off[11:0]};
  endfunction

  function automatic stack_cpu_pkg::alu_op_t binary_op(input int idx);
    case (idx)
      0:       return stack_cpu_pkg::ALU_ADD;
      1:       return stack_cpu_pkg::ALU_SUB;
      2:       return stack_cpu_pkg::ALU_AND;
      3:       return stack_cpu_pkg::ALU_OR;
      4:       return stack_cpu_pkg::ALU_XOR;
      5:       return stack_cpu_pkg::ALU_SHR;
      6:       return stack_cpu_pkg::ALU_SHL;
      7:       return stack_cpu_pkg::ALU_EQ;
      default: return stack_cpu_pkg::ALU_LT;
    endcase
  endfunction

  function automatic stack_cpu_pkg::alu_op_t unary_op(input int idx);
    case (idx)
      0:       return stack_cpu_pkg::ALU_INC;
      1:       return stack_cpu_pkg::ALU_NOT;
      default: return stack_cpu_pkg::ALU_PASS_A;  // NOP
    endcase
  endfunction

  // a is the top, b the second entry or immediate
  function automatic stack_cpu_pkg::word_t alu_model(input stack_cpu_pkg::alu_op_t op,
                                                     input stack_cpu_pkg::word_t a,
                                                     input stack_cpu_pkg::word_t b);
    case (op)
      stack_cpu_pkg::ALU_INC:    return a + 16'd1;
      stack_cpu_pkg::ALU_NOT:    return ~a;
      stack_cpu_pkg::ALU_PASS_B: return b;
      stack_cpu_pkg::ALU_AND:    return a & b;
      stack_cpu_pkg::ALU_OR:     return a | b;
      stack_cpu_pkg::ALU_XOR:    return a ^ b;
      stack_cpu_pkg::ALU_SHR:    return b >> a;
      stack_cpu_pkg::ALU_SHL:    return b << a;
      stack_cpu_pkg::ALU_ADD:    return a + b;
      stack_cpu_pkg::ALU_SUB:    return b - a;
      stack_cpu_pkg::ALU_EQ:     return {15'b0, a == b};
      stack_cpu_pkg::ALU_LT:     return {15'b0, $signed(b) < $signed(a)};
      default:                   return a;
    endcase
  endfunction

  task automatic emit(input stack_cpu_pkg::insn_t w);
    pmem[pc[9:0]] = w;
    pc++;
  endtask

  task automatic start_program();
    for (int i = 0; i < 1024; i++)
      pmem[i[9:0]] = jump(-1);  // stray fetches just spin
    pc = 0;
  endtask

  // instruction-level model, runs until ip reaches the halt loop
  task automatic run_model(input int halt);
    stack_cpu_pkg::word_t ip;
    stack_cpu_pkg::word_t fp;
    stack_cpu_pkg::word_t dp;
    stack_cpu_pkg::word_t a;
    stack_cpu_pkg::word_t b;
    stack_cpu_pkg::word_t base;
    stack_cpu_pkg::word_t addr;
    stack_cpu_pkg::word_t ds [$];
    stack_cpu_pkg::word_t cs [$];
    stack_cpu_pkg::insn_t w;
    int steps;
    ip = '0;
    fp = stack_cpu_pkg::FP_RESET;
    dp = '0;
    steps = 0;
    exp_q.delete();
    rd_q.delete();
    mmem.delete();
    while (int'(ip) != halt) begin
      w = pmem[ip[9:0]];
      ip = ip + 16'd1;  // offsets count from the next word
      steps++;
      if (steps > 2000)
        abort("model did not reach the halt address");
      if (w[17:16] == 2'b11) begin
        ds.push_back(w[15:0]);
      end else if (w[17:16] == 2'b10) begin
        a = ds.pop_back();
        ds.push_back(alu_model(w[15:10], a, {6'b0, w[9:0]}));
      end else if (w[17:14] == 4'b0000) begin
        cs.push_back(ip);
        ip = ip + {{2{w[13]}}, w[13:0]};
      end else if (w[17:12] == 6'b000100) begin
        ip = ip + {{4{w[11]}}, w[11:0]};
      end else if (w[17:12] == 6'b000101) begin
        fp = fp + {{4{w[11]}}, w[11:0]};
      end else if (w[17:12] == 6'b000110) begin
        a = ds.pop_back();
        if (a == '0)
          ip = ip + {{4{w[11]}}, w[11:0]};
      end else if (w[17:15] == 3'b010) begin
        base = (w[13:12] == 2'd1) ? fp : (w[13:12] == 2'd2) ? dp : '0;
        if (w[14]) begin
          ds.push_back(base + {4'b0, w[11:0]});  // PUSH X+uimm12
        end else begin
          addr = base + {4'b0, w[11:1], 1'b0};
          if (w[0]) begin
            a = ds.pop_back();
            mmem[addr] = a;
            exp_q.push_back({addr, a});
          end else begin
            rd_q.push_back(addr);
            ds.push_back(mmem.exists(addr) ? mmem[addr] : fill(int'(addr)));
            steps++;  // extra writeback cycle
          end
        end
      end else if (w[17:11] == 7'b0111000) begin
        a = ds.pop_back();
        b = (ds.size() > 0) ? ds[$] : '0;
        if (w[6])
          b = ds.pop_back();
        else if (w[7])
          ds.push_back(a);  // DUP keeps the old top below
        ds.push_back(alu_model(w[5:0], a, b));
      end else if (w[17:11] == 7'b0111001) begin
        case (w[5:0])
          6'h00:   ip = cs.pop_back();
          6'h02:   fp = cs.pop_back();
          6'h03:   cs.push_back(fp);
          6'h20:   fp = ds.pop_back();
          6'h21:   dp = ds.pop_back();
          default: ;
        endcase
      end
    end
    n_expected = exp_q.size();
    limit = steps * 4 + 8 + 40;  // reset, halt loop and margin
  endtask

  task automatic run_program(input int halt);
    logic [15:0] seen [3];  // pmem_addr at the last three falling edges
    logic        looped;
    rst = 1'b1;
    run_model(halt);
    for (int i = 0; i < 65536; i++)
      dmem[i[15:0]] = fill(i);
    n_writes = 0;
    start_cyc = cyc;
    repeat (8) @(negedge clk);
    check("dmem_ren", {15'b0, dmem_ren}, '0);
    check("dmem_wen", {15'b0, dmem_wen}, '0);
    check("pmem_addr", pmem_addr, '0);
    rst = 1'b0;
    seen[0] = pmem_addr;
    seen[1] = pmem_addr;
    seen[2] = pmem_addr;
    looped = 1'b0;
    // a one-word loop jumps back to the fetch address of three cycles ago
    while (!looped) begin
      @(negedge clk);
      looped  = (pmem_addr == seen[2]) && (pmem_addr != seen[0]);
      seen[2] = seen[1];
      seen[1] = seen[0];
      seen[0] = pmem_addr;
    end
    check("halt pmem_addr", pmem_addr, stack_cpu_pkg::word_t'(halt));
    check("write count", stack_cpu_pkg::word_t'(n_writes),
          stack_cpu_pkg::word_t'(n_expected));
    check("pending reads", stack_cpu_pkg::word_t'(rd_q.size()), 16'd0);
  endtask

  task automatic build_random_test(output int halt);
    int depth;
    int k;
    start_program();
    emit(push16(16'h0100));
    emit(misc_op(6'h21));  // dp = 0x100
    emit(push16(stack_cpu_pkg::word_t'($urandom)));
    emit(push16(stack_cpu_pkg::word_t'($urandom)));
    depth = 2;
    for (int i = 0; i < 20; i++) begin
      k = int'($urandom % 4);
      if (k == 0 && depth < 8) begin
        emit(push16(stack_cpu_pkg::word_t'($urandom)));
        depth++;
      end else if (k == 1) begin
        emit(binop_imm(binary_op(int'($urandom % 9)), 10'($urandom)));
      end else if (k == 2) begin
        emit(stack_op(1'b0, 1'b0, unary_op(int'($urandom % 3))));
      end else if (depth > 2) begin
        emit(stack_op(1'b0, 1'b1, binary_op(int'($urandom % 9))));
        depth--;
      end else begin
        emit(stack_op(1'b1, 1'b0, stack_cpu_pkg::ALU_PASS_A));
        depth++;
      end
      emit(stack_op(1'b1, 1'b0, stack_cpu_pkg::ALU_PASS_A));  // copy for the store
      emit(mem_access(2'd2, int'($urandom % 64) * 2, 1'b1));
    end
    halt = pc;
    emit(jump(-1));
  endtask

  task automatic build_memory_test(output int halt);
    start_program();
    emit(push16(16'h0200));
    emit(misc_op(6'h21));
    emit(push16(16'h1234));
    emit(mem_access(2'd2, 4, 1'b1));
    emit(push16(16'hbeef));
    emit(mem_access(2'd1, 16, 1'b1));
    emit(add_fp(-32));  // new frame
    emit(push16(16'h5555));
    emit(mem_access(2'd1, 2, 1'b1));
    emit(mem_access(2'd2, 4, 1'b0));
    emit(mem_access(2'd1, 2, 1'b0));
    emit(stack_op(1'b0, 1'b1, stack_cpu_pkg::ALU_ADD));
    emit(mem_access(2'd2, 8, 1'b1));
    emit(add_fp(32));
    emit(mem_access(2'd1, 16, 1'b0));
    emit(mem_access(2'd0, 32, 1'b1));  // absolute address
    emit(push_x(2'd1, 6));
    emit(mem_access(2'd2, 10, 1'b1));
    emit(push_x(2'd0, 48));
    emit(misc_op(6'h20));  // POP fp
    emit(push_x(2'd1, 0));
    emit(mem_access(2'd2, 12, 1'b1));
    halt = pc;
    emit(jump(-1));
  endtask

  task automatic build_branch_test(output int halt);
    int call_at;
    int call2_at;
    int loop_at;
    int f1;
    int f2;
    start_program();
    emit(push16(16'h0300));
    emit(misc_op(6'h21));
    emit(push16(16'h0000));
    emit(jump_zero(2));     // taken
    emit(push16(16'hdead));
    emit(mem_access(2'd2, 0, 1'b1));
    emit(push16(16'h0005));
    emit(jump_zero(2));     // not taken
    emit(push16(16'h0011));
    emit(mem_access(2'd2, 2, 1'b1));
    call_at = pc;
    emit(18'd0);            // call f1, patched below
    emit(push16(16'h0022));
    emit(mem_access(2'd2, 4, 1'b1));
    emit(push16(16'h0003));
    loop_at = pc;           // counts 3 down to 0
    emit(stack_op(1'b1, 1'b0, stack_cpu_pkg::ALU_PASS_A));
    emit(mem_access(2'd2, 6, 1'b1));
    emit(push16(16'h0001));
    emit(stack_op(1'b0, 1'b1, stack_cpu_pkg::ALU_SUB));
    emit(stack_op(1'b1, 1'b0, stack_cpu_pkg::ALU_PASS_A));
    emit(jump_zero(1));
    emit(jump(loop_at - (pc + 1)));  // backward
    emit(stack_op(1'b0, 1'b1, stack_cpu_pkg::ALU_PASS_B));
    emit(jump(2));          // forward over a dead store
    emit(push16(16'h0bad));
    emit(mem_access(2'd2, 0, 1'b1));
    halt = pc;
    emit(jump(-1));
    f1 = pc;
    emit(misc_op(6'h03));
    emit(add_fp(-16));
    emit(push16(16'h0033));
    emit(mem_access(2'd1, 0, 1'b1));
    call2_at = pc;
    emit(18'd0);
    emit(misc_op(6'h02));
    emit(push_x(2'd1, 0));  // fp back to its caller value
    emit(mem_access(2'd2, 8, 1'b1));
    emit(misc_op(6'h00));
    f2 = pc;
    emit(misc_op(6'h03));
    emit(add_fp(-16));
    emit(push_x(2'd1, 0));
    emit(mem_access(2'd2, 10, 1'b1));
    emit(misc_op(6'h02));
    emit(misc_op(6'h00));
    pmem[call_at[9:0]]  = call_to(f1 - (call_at + 1));
    pmem[call2_at[9:0]] = call_to(f2 - (call2_at + 1));
  endtask

  initial begin
    int halt;
    void'($urandom(32'hc502));
    rst = 1'b1;
    pmem_rdata = '0;
    dmem_rdata = '0;
    @(negedge clk);
    repeat (4) begin
      rst = 1'b1;  // keep the core quiet while pmem changes
      build_random_test(halt);
      run_program(halt);
    end
    rst = 1'b1;
    build_memory_test(halt);
    run_program(halt);
    rst = 1'b1;
    build_branch_test(halt);
    run_program(halt);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
stack_cpu_pkg.sv
stack.sv
alu.sv
insn_decoder.sv
cpu.sv
cpu_properties.sv
tb_cpu.sv

/* Makefile */
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir
